/* build.f */
+incdir+src
src/pkg_vec.sv
src/lane_unit.sv
src/mem_arbiter.sv
src/vec_mem.sv
src/vector_unit.sv
test/tb_vector_unit.sv

/* src/lane_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module lane_unit
	import pkg_vec::*;
#(
	parameter int LANE_ID = 0
) (
	input	wire				clock,
	input	wire				arst_n,
	input	wire				accept,		// Command taken this edge
	input	wire				en,			// Lane enable bit
	input	wire vec_cmd_t		cmd,
	input	wire data_t			scalar_in,
	input	wire data_t			nbr_src,	// src1 of next lane
	output	data_t				src1_out,	// Our src1 onto the ring
	output	wb_req_t			wb_req,
	input	wire wb_rsp_t		wb_rsp,
	output	logic				done,
	output	logic				zero		// Last write was zero
);

	data_t		regs [`VEC_NUM_REG];
	data_t		src2_val;
	data_t		alu_res;
	logic		is_alu;
	logic		is_mem;
	logic		mem_open;		// Wishbone cycle in progress
	logic		mem_we;
	addr_t		mem_adr;
	data_t		mem_dat;
	reg_idx_t	ld_dst;			// Load target held over the bus cycle
	logic		mem_done;

	assign src1_out	= regs[cmd.src1];
	assign src2_val	= regs[cmd.src2];

	assign is_alu	= cmd.op inside {op_add, op_sub, op_mul, op_bcast, op_rot};
	assign is_mem	= cmd.op inside {op_ld, op_st};
	assign mem_done	= mem_open && wb_rsp.ack;

	//////////////////////////////////////////////////////////////////////
	// Single-cycle datapath

	always_comb begin
		case (cmd.op)
			op_add:		alu_res = src1_out + src2_val;
			op_sub:		alu_res = src1_out - src2_val;
			op_mul:		alu_res = src1_out * src2_val;		// Keeps low 32 bits
			op_bcast:	alu_res = scalar_in;
			op_rot:		alu_res = nbr_src;					// Ring neighbour
			default:	alu_res = src1_out;					// Unused by mem/ext
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Register file, status and done

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `VEC_NUM_REG; r++) begin
				regs[r] <= '0;
			end
			zero <= 1'b0;
			done <= 1'b0;
			mem_open <= 1'b0;
		end else if (accept) begin
			done <= !en || !is_mem;				// Disabled lanes finish at once
			if (en && is_alu) begin
				regs[cmd.dst] <= alu_res;
				zero <= (alu_res == '0);
			end
			mem_open <= en && is_mem;			// Raise cyc/stb
		end else if (mem_done) begin
			done <= 1'b1;
			mem_open <= 1'b0;					// Drop after ack
			if (!mem_we) begin
				regs[ld_dst] <= wb_rsp.dat;		// Load result
				zero <= (wb_rsp.dat == '0);
			end
		end
	end

	// Bus payload, held stable until ack
	always_ff @(posedge clock) begin
		if (accept) begin
			mem_we <= (cmd.op == op_st);
			mem_adr <= cmd.imm + addr_t'(LANE_ID);	// Per-lane word offset
			mem_dat <= src1_out;
			ld_dst <= cmd.dst;
		end
	end

	assign wb_req.cyc	= mem_open;
	assign wb_req.stb	= mem_open;
	assign wb_req.we	= mem_we;
	assign wb_req.adr	= mem_adr;
	assign wb_req.dat	= mem_dat;

	// Top must not issue while this lane still owns a bus cycle
	a_no_accept_in_cycle: assert property (
		@(posedge clock) disable iff (!arst_n)
		accept |-> !mem_open
	);

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module mem_arbiter
	import pkg_vec::*;
(
	input	wire			clock,
	input	wire			arst_n,
	input	wire wb_req_t	m_req [`VEC_NUM_LANE],	// One per lane
	output	wb_rsp_t		m_rsp [`VEC_NUM_LANE],
	output	wb_req_t		s_req,					// To memory
	input	wire wb_rsp_t	s_rsp
);

	localparam int SEL_W = $clog2(`VEC_NUM_LANE);

	lane_mask_t			grant_q;	// Held owner
	lane_mask_t			pick;		// Next owner when idle
	lane_mask_t			grant;
	logic [SEL_W-1:0]	ptr;		// Highest priority lane
	logic [SEL_W-1:0]	owner;
	logic [SEL_W-1:0]	idx;

	//////////////////////////////////////////////////////////////////////
	// Round-robin pick from ptr

	always_comb begin
		pick = '0;
		idx = '0;
		for (int k = 0; k < `VEC_NUM_LANE; k++) begin
			idx = ptr + SEL_W'(k);			// Wraps around the ring
			if (pick == '0 && m_req[idx].cyc) begin
				pick[idx] = 1'b1;
			end
		end
	end

	assign grant = (grant_q != '0) ? grant_q : pick;	// New owner only when idle

	always_comb begin
		owner = '0;
		for (int k = 0; k < `VEC_NUM_LANE; k++) begin
			if (grant[k]) begin
				owner = SEL_W'(k);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request forward and ack return

	assign s_req = (grant != '0) ? m_req[owner] : '0;

	always_comb begin
		for (int k = 0; k < `VEC_NUM_LANE; k++) begin
			m_rsp[k].ack = s_rsp.ack && grant[k];	// Owner only
			m_rsp[k].dat = s_rsp.dat;				// Read data to all
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			grant_q <= '0;
			ptr <= '0;
		end else if (s_rsp.ack) begin
			grant_q <= '0;					// Transfer done, bus free
			ptr <= owner + 1'b1;			// Lane after the one served
		end else if (s_req.cyc) begin
			grant_q <= grant;				// Hold while cyc stays up
		end else begin
			grant_q <= '0;
		end
	end

	// Ack goes back to exactly one held owner
	a_ack_to_owner: assert property (
		@(posedge clock) disable iff (!arst_n)
		s_rsp.ack |-> $onehot(grant_q)
	);

endmodule

`default_nettype wire

/* src/pkg_vec.sv */
`default_nettype none

`include "vec_params.svh"

package pkg_vec;

	typedef logic [`VEC_DATA_W-1:0]		data_t;			// One data word
	typedef logic [`VEC_NUM_LANE-1:0]	lane_mask_t;	// One bit per lane
	typedef logic [`VEC_ADDR_W-1:0]		addr_t;			// Memory word address
	typedef logic [`VEC_REG_W-1:0]		reg_idx_t;		// Register index

	typedef enum logic [2:0] {
		op_add		= 3'd0,		// dst = src1 + src2
		op_sub		= 3'd1,		// dst = src1 - src2
		op_mul		= 3'd2,		// Low half of product
		op_bcast	= 3'd3,		// dst = scalar input
		op_rot		= 3'd4,		// dst = src1 of next lane
		op_ld		= 3'd5,		// dst = mem[imm + lane]
		op_st		= 3'd6,		// mem[imm + lane] = src1
		op_ext		= 3'd7		// Scalar out = src1 of lane_sel
	} opcode_e;

	typedef struct packed {
		opcode_e							op;
		reg_idx_t							dst;
		reg_idx_t							src1;
		reg_idx_t							src2;
		logic [$clog2(`VEC_NUM_LANE)-1:0]	lane_sel;	// Lane for extract
		addr_t								imm;		// Load/store base
	} vec_cmd_t;

	typedef struct packed {
		logic	cyc;
		logic	stb;
		logic	we;
		addr_t	adr;
		data_t	dat;		// Write data
	} wb_req_t;

	typedef struct packed {
		logic	ack;
		data_t	dat;		// Read data
	} wb_rsp_t;

endpackage

`default_nettype wire

/* src/vec_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_mem
	import pkg_vec::*;
(
	input	wire			clock,
	input	wire			arst_n,
	input	wire wb_req_t	wb_req,
	output	wb_rsp_t		wb_rsp
);

	data_t	mem [`VEC_MEM_DEPTH];
	data_t	rd_q;			// Read data, valid with ack
	logic	ack_q;
	logic	strobe;

	// New strobe only, not the ack cycle
	assign strobe = wb_req.cyc && wb_req.stb && !ack_q;

	always_ff @(posedge clock) begin
		if (strobe && wb_req.we) begin
			mem[wb_req.adr] <= wb_req.dat;
		end
		if (strobe) begin
			rd_q <= mem[wb_req.adr];		// Old word on a write
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= strobe;				// One-cycle ack
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_q;

	// Master must hold the strobe until it sees ack
	a_ack_with_strobe: assert property (
		@(posedge clock) disable iff (!arst_n)
		ack_q |-> (wb_req.cyc && wb_req.stb)
	);

endmodule

`default_nettype wire

/* src/vec_params.svh */
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Lane array shape
`define VEC_NUM_LANE	4		// Lanes in the unit
`define VEC_DATA_W		32		// Data word width

// Per-lane register file
`define VEC_NUM_REG		8		// Registers per lane
`define VEC_REG_W		3		// Register index width

// Shared data memory
`define VEC_MEM_DEPTH	64		// Words in memory
`define VEC_ADDR_W		6		// Word address width

`endif

/* src/vector_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vector_unit
	import pkg_vec::*;
(
	input	wire				clock,
	input	wire				arst_n,
	input	wire				cmd_valid,
	output	logic				cmd_ready,
	input	wire vec_cmd_t		cmd,
	input	wire lane_mask_t	en_lane,		// Lane enable mask
	input	wire data_t			scalar_in,
	output	data_t				scalar_out,
	output	lane_mask_t			status,			// Per-lane zero flag
	output	logic				commit
);

	logic			busy;			// Command outstanding
	logic			accept;
	lane_mask_t		en_q;			// Mask of the running command
	lane_mask_t		lane_done;
	logic			all_done;
	data_t			src1_ring [`VEC_NUM_LANE];
	wb_req_t		lane_req [`VEC_NUM_LANE];
	wb_rsp_t		lane_rsp [`VEC_NUM_LANE];
	wb_req_t		mem_req;
	wb_rsp_t		mem_rsp;

	//////////////////////////////////////////////////////////////////////
	// Command handshake and commit

	assign cmd_ready	= !busy;
	assign accept		= cmd_valid && cmd_ready;
	assign all_done		= &(lane_done | ~en_q);		// Done or not enabled

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			en_q <= '0;
			commit <= 1'b0;
			scalar_out <= '0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				en_q <= en_lane;
			end else if (commit) begin
				busy <= 1'b0;				// Ready again next cycle
			end
			commit <= busy && all_done && !commit;	// Single pulse
			if (accept && cmd.op == op_ext) begin
				scalar_out <= src1_ring[cmd.lane_sel];
			end
		end
	end

	// Commit within two cycles per lane after accept
	a_commit_latency: assert property (
		@(posedge clock) disable iff (!arst_n)
		accept |-> ##[2:2*`VEC_NUM_LANE+2] commit
	);

	//////////////////////////////////////////////////////////////////////
	// Lanes and neighbour ring

	for (genvar i = 0; i < `VEC_NUM_LANE; i++) begin : g_lane
		lane_unit #(
			.LANE_ID	(i)
		) u_lane (
			.clock		(clock),
			.arst_n		(arst_n),
			.accept		(accept),
			.en			(en_lane[i]),
			.cmd		(cmd),
			.scalar_in	(scalar_in),
			.nbr_src	(src1_ring[(i + 1) % `VEC_NUM_LANE]),	// Lane i+1
			.src1_out	(src1_ring[i]),
			.wb_req		(lane_req[i]),
			.wb_rsp		(lane_rsp[i]),
			.done		(lane_done[i]),
			.zero		(status[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Shared memory bus

	mem_arbiter u_arbiter (
		.clock		(clock),
		.arst_n		(arst_n),
		.m_req		(lane_req),
		.m_rsp		(lane_rsp),
		.s_req		(mem_req),
		.s_rsp		(mem_rsp)
	);

	vec_mem u_mem (
		.clock		(clock),
		.arst_n		(arst_n),
		.wb_req		(mem_req),
		.wb_rsp		(mem_rsp)
	);

endmodule

`default_nettype wire

/* test/tb_vector_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module tb_vector_unit
	import pkg_vec::*;
();

	localparam int MAX_CYCLES = 300 * 12 + 10;	// Commands times worst latency, plus reset

	logic		clock;
	logic		arst_n;
	logic		cmd_valid;
	logic		cmd_ready;
	vec_cmd_t	cmd;
	lane_mask_t	en_lane;
	data_t		scalar_in;
	data_t		scalar_out;
	lane_mask_t	status;
	logic		commit;

	data_t		m_regs [`VEC_NUM_LANE][`VEC_NUM_REG];	// Model register files
	data_t		m_mem [`VEC_MEM_DEPTH];					// Model memory
	lane_mask_t	m_zero;									// Model zero flags
	data_t		m_scalar;
	data_t		exp_q [$];		// Extract results awaiting check
	logic		outstanding;	// Accepted, not yet committed
	int			errors;
	int			err_mark;
	int			cmd_cnt;
	int			commit_cnt;
	int			pass_cnt;
	int			fail_cnt;
	int			cycle_cnt;

	vector_unit u_dut (
		.clock		(clock),
		.arst_n		(arst_n),
		.cmd_valid	(cmd_valid),
		.cmd_ready	(cmd_ready),
		.cmd		(cmd),
		.en_lane	(en_lane),
		.scalar_in	(scalar_in),
		.scalar_out	(scalar_out),
		.status		(status),
		.commit		(commit)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;		// 100 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and helpers

	function automatic data_t model_cmd(vec_cmd_t c, lane_mask_t m, data_t s);
		data_t	old [`VEC_NUM_LANE][`VEC_NUM_REG];
		data_t	v;
		int		a;
		old = m_regs;					// All lanes read before any write
		for (int i = 0; i < `VEC_NUM_LANE; i++) begin
			a = (c.imm + i) % `VEC_MEM_DEPTH;		// Address wraps
			v = '0;
			if (m[i]) begin
				case (c.op)
					op_add:		v = old[i][c.src1] + old[i][c.src2];
					op_sub:		v = old[i][c.src1] - old[i][c.src2];
					op_mul:		v = old[i][c.src1] * old[i][c.src2];
					op_bcast:	v = s;
					op_rot:		v = old[(i + 1) % `VEC_NUM_LANE][c.src1];
					op_ld:		v = m_mem[a];
					op_st:		m_mem[a] = old[i][c.src1];
					default:	v = '0;
				endcase
				if (c.op != op_st && c.op != op_ext) begin
					m_regs[i][c.dst] = v;
					m_zero[i] = (v == '0);
				end
			end
		end
		if (c.op == op_ext) begin
			m_scalar = old[c.lane_sel][c.src1];	// Mask plays no part
		end
		return m_scalar;
	endfunction

	function automatic vec_cmd_t make_cmd(opcode_e op, int dst, int src1, int src2,
			int sel, int imm);
		vec_cmd_t	c;
		c.op = op;
		c.dst = reg_idx_t'(dst);
		c.src1 = reg_idx_t'(src1);
		c.src2 = reg_idx_t'(src2);
		c.lane_sel = 2'(sel);
		c.imm = addr_t'(imm);
		return c;
	endfunction

	task automatic check_eq(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Drive on the falling edge, hold until accept, wait for commit
	task automatic issue(input vec_cmd_t c, input lane_mask_t m, input data_t s);
		data_t	exp;
		while (!cmd_ready) @(negedge clock);
		cmd_valid = 1'b1;
		cmd = c;
		en_lane = m;
		scalar_in = s;
		exp = model_cmd(c, m, s);
		@(posedge clock);				// Accept edge
		outstanding = 1'b1;
		cmd_cnt++;
		@(negedge clock);
		cmd_valid = 1'b0;
		while (!commit) @(negedge clock);
		if (c.op == op_ext) begin
			exp_q.push_back(exp);
		end
	endtask

	task automatic extract_all();
		for (int l = 0; l < `VEC_NUM_LANE; l++) begin
			for (int r = 0; r < `VEC_NUM_REG; r++) begin
				issue(make_cmd(op_ext, 0, r, 0, l, 0), lane_mask_t'($urandom()), '0);
			end
		end
	endtask

	task automatic start_test();
		err_mark = errors;
	endtask

	task automatic end_test(input string name);
		repeat (2) @(negedge clock);	// Let the checker drain
		if (errors == err_mark) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - err_mark);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checker, protocol monitor and watchdog

	initial begin : extract_checker
		forever begin
			@(negedge clock);
			while (exp_q.size() > 0) begin
				check_eq(scalar_out, exp_q.pop_front(), "scalar_out after extract");
			end
		end
	end

	always @(negedge clock) begin
		if (arst_n) begin
			if (outstanding && cmd_ready) begin
				$display("ERROR %0t: cmd_ready is high while a command is outstanding", $time);
				errors++;
			end
			if (commit) begin
				if (!outstanding) begin
					$display("ERROR %0t: commit pulsed with no command outstanding", $time);
					errors++;
				end
				commit_cnt++;
				outstanding = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("ERROR: the run timed out without finishing");
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main
		int	seed;
		int	d;
		int	base;
		seed = 32'h123e_c1ff;
		void'($urandom(seed));
		cmd_valid = 1'b0;
		cmd = '0;
		en_lane = '0;
		scalar_in = '0;
		arst_n = 1'b0;
		outstanding = 1'b0;
		errors = 0;
		cmd_cnt = 0;
		commit_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		m_zero = '0;
		m_scalar = '0;
		for (int l = 0; l < `VEC_NUM_LANE; l++) begin
			for (int r = 0; r < `VEC_NUM_REG; r++) begin
				m_regs[l][r] = '0;
			end
		end
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		start_test();
		check_eq(cmd_ready, 32'd1, "cmd_ready after reset");
		check_eq(commit, '0, "commit after reset");
		check_eq(status, '0, "status after reset");
		check_eq(scalar_out, '0, "scalar_out after reset");
		end_test("reset state");

		start_test();
		for (int r = 0; r < `VEC_NUM_REG; r++) begin
			issue(make_cmd(op_bcast, r, 0, 0, 0, 0), 4'hf, $urandom());
		end
		for (int n = 0; n < 40; n++) begin
			d = $urandom_range(2, 0);	// add, sub or mul
			issue(make_cmd(opcode_e'(d), $urandom_range(7, 0), $urandom_range(7, 0),
				$urandom_range(7, 0), 0, 0), lane_mask_t'($urandom()), '0);
			check_eq(status, m_zero, "status after ALU command");
		end
		extract_all();
		end_test("arithmetic");

		start_test();
		for (int l = 0; l < `VEC_NUM_LANE; l++) begin
			for (int r = 0; r < `VEC_NUM_REG; r++) begin
				issue(make_cmd(op_bcast, r, 0, 0, 0, 0), lane_mask_t'(1 << l), $urandom());
			end
		end
		for (int n = 0; n < 8; n++) begin
			issue(make_cmd(op_rot, $urandom_range(7, 0), $urandom_range(7, 0), 0, 0, 0),
				4'hf, '0);
		end
		extract_all();
		end_test("neighbour rotate");

		start_test();
		for (int n = 0; n < 6; n++) begin
			base = $urandom_range(63, 0);
			d = $urandom_range(7, 0);
			issue(make_cmd(op_st, 0, d, 0, 0, base), 4'hf, '0);		// All lanes contend
			issue(make_cmd(op_ld, (d + 1 + $urandom_range(6, 0)) % 8, 0, 0, 0, base),
				lane_mask_t'($urandom()), '0);
			check_eq(status, m_zero, "status after load");
		end
		extract_all();
		end_test("store/load round trip");

		start_test();
		issue(make_cmd(op_add, 1, 2, 3, 0, 0), 4'h0, '0);		// Empty masks
		issue(make_cmd(op_ld, 4, 0, 0, 0, 8), 4'h0, '0);
		issue(make_cmd(op_st, 0, 5, 0, 0, 8), 4'h0, '0);
		issue(make_cmd(op_ext, 0, 6, 0, 2, 0), 4'h0, '0);
		@(negedge clock);
		check_eq(commit_cnt, cmd_cnt, "commit pulses against accepted commands");
		end_test("one commit per command");

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
